// ==== sources.f ====
common/dma_geom_pkg.sv
common/dma_ctrl_pkg.sv
source/dma_ctrl_fsm.sv
source/dma_cmd_check.sv
source/dma_xfer_tracker.sv
source/dma_burst_splitter.sv
source/dma_data_fifo.sv
source/axi_dma_core.sv
verification/axi_dma_sva.sv
verification/axi_dma_tb.sv

// ==== Bender.yml ====
package:
  name: axi_dma

sources:
  - files:
      - common/dma_geom_pkg.sv
      - common/dma_ctrl_pkg.sv
  - files:
      - source/dma_ctrl_fsm.sv
      - source/dma_cmd_check.sv
      - source/dma_xfer_tracker.sv
      - source/dma_burst_splitter.sv
      - source/dma_data_fifo.sv
      - source/axi_dma_core.sv
  - target: test
    files:
      - verification/axi_dma_sva.sv
      - verification/axi_dma_tb.sv

// ==== verification/axi_dma_tb.sv ====
module axi_dma_tb import dma_geom_pkg::*, dma_ctrl_pkg::*; ;

    timeunit 1ns;
    timeprecision 100ps;

    // Bytes over all tests and number of tests, for the watchdog
    localparam int TOTAL_BYTES = 1934;
    localparam int NUM_TESTS   = 13;
    localparam real LIMIT_NS   = (40.0 * TOTAL_BYTES + 200.0 * NUM_TESTS) * 4.0;

    logic clk;
    logic rst_n;
    logic go_i, flush_i;
    addr_t src_addr_i, dst_addr_i;
    count_t byte_count_i, block_size_i;
    logic rd_req_valid_o, rd_req_ready_i, r_valid_i, r_ready_o;
    addr_t rd_req_addr_o, wr_req_addr_o;
    len_t rd_req_len_o, wr_req_len_o;
    data_t r_data_i, w_data_o;
    logic wr_req_valid_o, wr_req_ready_i, w_valid_o, w_ready_i;
    logic rd_resp_valid_i, rd_resp_err_i, wr_resp_valid_i, wr_resp_err_i;
    logic busy_o, done_o, error_o;
    count_t bytes_remaining_o;

    int mismatches, failures, sva_fails;
    addr_t exp_rd_addr[$], exp_wr_addr[$];
    len_t exp_rd_len[$], exp_wr_len[$];
    addr_t rd_words[$];
    bit rd_last[$];
    int wr_due[$];
    addr_t wr_slots[$];
    data_t dst_mem[addr_t];
    addr_t cur_src;
    int cycle, wr_idx, done_seen, rd_resp_due, stall_left, resp_at;
    int rd_acc, wr_words;
    count_t exp_rem;
    bit rd_err_arm, wr_err_arm, bp_mode;

    axi_dma_core i_dut (.*);

    bind dma_burst_splitter axi_dma_sva i_sva (.*);

    always #2 clk = ~clk;

    // Expected data word for a source address
    function automatic data_t ref_word(input addr_t a);
        return a ^ {a[15:0], a[31:16]} ^ 32'h5a3c_96e1;
    endfunction

    task automatic split_ref(input addr_t base, input count_t cnt, input count_t bs,
                             ref addr_t aq[$], ref len_t lq[$]);
        count_t blk;
        count_t ofs;
        count_t l;
        blk = ((bs == 0) || (bs > 64)) ? 64 : bs;
        ofs = 0;
        while (ofs < cnt) begin
            l = blk - ((base + ofs) % blk);
            if (l > cnt - ofs) begin
                l = cnt - ofs;
            end
            aq.push_back(base + ofs);
            lq.push_back(len_t'(l));
            ofs += l;
        end
    endtask

    task automatic check_word(input string name, input data_t exp, input data_t act);
        if (exp !== act) begin
            $display("MISMATCH t=%0t %s exp=%h act=%h", $time, name, exp, act);
            mismatches++;
        end
    endtask

    task automatic check_count(input string name, input count_t exp, input count_t act);
        if (exp !== act) begin
            $display("MISMATCH t=%0t %s exp=%0d act=%0d", $time, name, exp, act);
            mismatches++;
        end
    endtask

    task automatic check_req(input string pfx, input addr_t ea, input addr_t aa,
                             input len_t el, input len_t al);
        if (ea !== aa) begin
            $display("MISMATCH t=%0t %s_addr_o exp=%h act=%h", $time, pfx, ea, aa);
            mismatches++;
        end
        if (el !== al) begin
            $display("MISMATCH t=%0t %s_len_o exp=%0d act=%0d", $time, pfx, el, al);
            mismatches++;
        end
    endtask

    // Status levels follow from the expected FSM state
    task automatic check_status(input dma_state_e st);
        logic eb;
        logic ed;
        logic ee;
        eb = (st != DMA_IDLE);
        ed = (st == DMA_DONE);
        ee = (st == DMA_ERROR);
        if ({eb, ed, ee} !== {busy_o, done_o, error_o}) begin
            $display("MISMATCH t=%0t busy/done/error exp=%b%b%b act=%b%b%b", $time,
                     eb, ed, ee, busy_o, done_o, error_o);
            mismatches++;
        end
    endtask

    // Read and write slave models
    initial begin
        void'($urandom(38));
        forever begin
            @(posedge clk);
            cycle++;
            if (rd_req_valid_o && rd_req_ready_i) begin
                for (int i = 0; i < rd_req_len_o / 4; i++) begin
                    rd_words.push_back(rd_req_addr_o + 4 * i);
                    rd_last.push_back(i == rd_req_len_o / 4 - 1);
                end
            end
            if (r_valid_i && r_ready_o) begin
                void'(rd_words.pop_front());
                if (rd_last.pop_front()) begin
                    rd_resp_due++;
                end
            end
            // Each response lands 0 to 8 cycles after its request
            if (wr_req_valid_o && wr_req_ready_i) begin
                resp_at = cycle + $urandom % 9;
                if (wr_due.size() > 0 && wr_due[$] >= resp_at) begin
                    resp_at = wr_due[$] + 1;
                end
                wr_due.push_back(resp_at);
                for (int i = 0; i < wr_req_len_o / 4; i++) begin
                    wr_slots.push_back(wr_req_addr_o + 4 * i);
                end
            end
            // Data lands at the address of the request it belongs to
            if (w_valid_o && w_ready_i) begin
                dst_mem[wr_slots.pop_front()] = w_data_o;
            end
            #0.5;
            rd_req_ready_i  = ($urandom % 3 != 0);
            rd_resp_valid_i = 1'b0;
            rd_resp_err_i   = 1'b0;
            if (rd_resp_due > 0) begin
                rd_resp_valid_i = 1'b1;
                rd_resp_due--;
                rd_resp_err_i = rd_err_arm;
                rd_err_arm = 1'b0;
            end
            wr_resp_valid_i = 1'b0;
            wr_resp_err_i   = 1'b0;
            if (wr_due.size() > 0 && wr_due[0] <= cycle) begin
                void'(wr_due.pop_front());
                wr_resp_valid_i = 1'b1;
                wr_resp_err_i = wr_err_arm;
                wr_err_arm = 1'b0;
            end
            if (rd_words.size() > 0 && (r_valid_i || $urandom % 4 != 0)) begin
                r_valid_i = 1'b1;
                r_data_i  = ref_word(rd_words[0]);
            end else begin
                r_valid_i = 1'b0;
            end
            // Write data only taken for words an accepted request announced
            if (stall_left > 0) begin
                w_ready_i = 1'b0;
                stall_left--;
            end else if (bp_mode) begin
                w_ready_i = (wr_slots.size() > 0);
                if ($urandom % 8 == 0) begin
                    stall_left = 1 + $urandom % 16;
                end
            end else begin
                w_ready_i = (wr_slots.size() > 0) && ($urandom % 4 != 0);
            end
        end
    end

    // Compare process
    always @(posedge clk) begin
        if (rst_n) begin
            check_count("bytes_remaining_o", exp_rem, bytes_remaining_o);
            if (done_o) begin
                done_seen++;
            end
            if (rd_req_valid_o && rd_req_ready_i) begin
                if (exp_rd_addr.size() == 0) begin
                    $display("Unexpected read request at t=%0t", $time);
                    failures++;
                end else begin
                    check_req("rd_req", exp_rd_addr.pop_front(), rd_req_addr_o,
                              exp_rd_len.pop_front(), rd_req_len_o);
                end
                rd_acc += rd_req_len_o;
                if (rd_acc - 4 * wr_words > FIFO_BYTES) begin
                    $display("Read data in flight exceeds FIFO capacity at t=%0t", $time);
                    failures++;
                end
            end
            if (wr_req_valid_o && wr_req_ready_i) begin
                if (exp_wr_addr.size() == 0) begin
                    $display("Unexpected write request at t=%0t", $time);
                    failures++;
                end else begin
                    check_req("wr_req", exp_wr_addr.pop_front(), wr_req_addr_o,
                              exp_wr_len.pop_front(), wr_req_len_o);
                end
            end
            if (w_valid_o && w_ready_i) begin
                check_word("w_data_o", ref_word(cur_src + 4 * wr_idx), w_data_o);
                wr_idx++;
                wr_words++;
            end
            if (!busy_o && go_i) begin
                exp_rem = byte_count_i;
            end else if (w_valid_o && w_ready_i) begin
                exp_rem -= 4;
            end
        end
    end

    task automatic run_copy(input addr_t src, input addr_t dst, input count_t cnt,
                            input count_t bs, input bit inj_rd, input bit inj_wr,
                            input bit bp, input bit illegal);
        int nwords;
        src_addr_i = src;
        dst_addr_i = dst;
        byte_count_i = cnt;
        block_size_i = bs;
        cur_src = src;
        wr_idx = 0;
        rd_acc = 0;
        wr_words = 0;
        done_seen = 0;
        nwords = illegal ? 0 : int'(cnt / 4);
        dst_mem.delete();
        if (!illegal) begin
            split_ref(src, cnt, bs, exp_rd_addr, exp_rd_len);
            split_ref(dst, cnt, bs, exp_wr_addr, exp_wr_len);
        end
        rd_err_arm = inj_rd;
        wr_err_arm = inj_wr;
        bp_mode = bp;
        go_i = 1'b1;
        @(posedge clk);
        #0.5;
        go_i = 1'b0;
        do begin
            @(posedge clk);
        end while (!(done_o || error_o));
        #0.5;
        if (illegal || inj_rd || inj_wr) begin
            check_status(DMA_ERROR);
            if (done_seen != 0) begin
                $display("Done pulse seen on a failing transfer at t=%0t", $time);
                failures++;
            end
            flush_i = 1'b1;
            @(posedge clk);
            #0.5;
            flush_i = 1'b0;
            @(posedge clk);
            #0.5;
        end else if (done_seen != 1) begin
            $display("Expected one done pulse, saw %0d at t=%0t", done_seen, $time);
            failures++;
        end
        check_status(DMA_IDLE);
        check_count("words written", nwords, wr_idx);
        if (!illegal) begin
            check_count("bytes_remaining_o", 0, bytes_remaining_o);
        end
        for (int i = 0; i < nwords; i++) begin
            if (!dst_mem.exists(dst + 4 * i)) begin
                $display("Destination word at %h never written", dst + 4 * i);
                failures++;
            end else begin
                check_word("dst_mem", ref_word(src + 4 * i), dst_mem[dst + 4 * i]);
            end
        end
        if (exp_rd_addr.size() != 0 || exp_wr_addr.size() != 0) begin
            $display("Expected requests never issued at t=%0t", $time);
            failures++;
        end
        exp_rd_addr.delete();
        exp_rd_len.delete();
        exp_wr_addr.delete();
        exp_wr_len.delete();
    endtask

    initial begin
        #(LIMIT_NS);
        $display("Watchdog expired before the tests finished");
        $display("Simulation failed");
        $finish;
    end

    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        go_i = 1'b0;
        flush_i = 1'b0;
        src_addr_i = '0;
        dst_addr_i = '0;
        byte_count_i = '0;
        block_size_i = '0;
        rd_req_ready_i = 1'b0;
        r_valid_i = 1'b0;
        r_data_i = '0;
        wr_req_ready_i = 1'b1;
        w_ready_i = 1'b0;
        rd_resp_valid_i = 1'b0;
        rd_resp_err_i = 1'b0;
        wr_resp_valid_i = 1'b0;
        wr_resp_err_i = 1'b0;
        exp_rem = '0;
        repeat (4) @(posedge clk);
        #0.5;
        rst_n = 1'b1;
        check_status(DMA_IDLE);
        if (!r_ready_o || w_valid_o || rd_req_valid_o || wr_req_valid_o) begin
            $display("Port levels after reset are wrong");
            failures++;
        end
        run_copy(32'h1000, 32'h8000, 0, 16, 0, 0, 0, 0);
        run_copy(32'h1000, 32'h8000, 4, 0, 0, 0, 0, 0);
        run_copy(32'h1010, 32'h8020, 60, 32, 0, 0, 0, 0);
        run_copy(32'h2004, 32'h9008, 64, 0, 0, 0, 0, 0);
        run_copy(32'h3000, 32'ha00c, 200, 8, 0, 0, 0, 0);
        run_copy(32'h4000, 32'hb000, 1024, 0, 0, 0, 1, 0);
        run_copy(32'h5000, 32'hc000, 256, 128, 0, 0, 1, 0);
        run_copy(32'h1002, 32'h8000, 16, 16, 0, 0, 0, 1);
        run_copy(32'h1000, 32'h8000, 6, 16, 0, 0, 0, 1);
        run_copy(32'h1000, 32'h8000, 16, 24, 0, 0, 0, 1);
        run_copy(32'h6000, 32'hd000, 128, 32, 0, 1, 0, 0);
        run_copy(32'h6100, 32'hd100, 96, 64, 1, 0, 0, 0);
        run_copy(32'h7000, 32'he000, 64, 16, 0, 0, 0, 0);
        sva_fails = i_dut.i_rd_split.i_sva.fail_count + i_dut.i_wr_split.i_sva.fail_count;
        $display("Errors: %0d mismatches, %0d other failures, %0d assertion failures",
                 mismatches, failures, sva_fails);
        if (mismatches == 0 && failures == 0 && sva_fails == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== verification/axi_dma_sva.sv ====
module axi_dma_sva import dma_geom_pkg::*; (
    input logic   clk,
    input logic   rst_n,
    input count_t block_size_i,
    input logic   req_valid_o,
    input logic   req_ready_i,
    input addr_t  req_addr_o,
    input len_t   req_len_o
);

    timeunit 1ns;
    timeprecision 100ps;

    count_t blk;
    count_t blk_ofs;
    int     fail_count = 0;

    // Effective block, zero or oversized means the largest block
    assign blk = ((block_size_i == '0) || (block_size_i > count_t'(MAX_BLOCK_BYTES))) ?
                 count_t'(MAX_BLOCK_BYTES) : block_size_i;
    assign blk_ofs = req_addr_o & (blk - count_t'(1));

    a_within_block: assert property (@(posedge clk) disable iff (!rst_n)
        (req_valid_o && req_ready_i) |-> (blk_ofs + count_t'(req_len_o) <= blk))
        else begin
            $error("request crosses a block boundary");
            fail_count++;
        end

    a_len_legal: assert property (@(posedge clk) disable iff (!rst_n)
        (req_valid_o && req_ready_i) |->
            ((req_len_o[1:0] == 2'b00) && (req_len_o >= len_t'(4)) &&
             (req_len_o <= len_t'(MAX_BLOCK_BYTES))))
        else begin
            $error("request length out of range");
            fail_count++;
        end

    a_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (req_valid_o && !req_ready_i) |=>
            (req_valid_o && $stable(req_addr_o) && $stable(req_len_o)))
        else begin
            $error("request dropped or changed before acceptance");
            fail_count++;
        end

endmodule

// ==== source/axi_dma_core.sv ====
module axi_dma_core
    import dma_geom_pkg::*;
    import dma_ctrl_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  logic   go_i,
    input  logic   flush_i,
    input  addr_t  src_addr_i,
    input  addr_t  dst_addr_i,
    input  count_t byte_count_i,
    input  count_t block_size_i,
    // Read request and data
    output logic   rd_req_valid_o,
    input  logic   rd_req_ready_i,
    output addr_t  rd_req_addr_o,
    output len_t   rd_req_len_o,
    input  logic   r_valid_i,
    input  data_t  r_data_i,
    output logic   r_ready_o,
    // Write request and data
    output logic   wr_req_valid_o,
    input  logic   wr_req_ready_i,
    output addr_t  wr_req_addr_o,
    output len_t   wr_req_len_o,
    output logic   w_valid_o,
    output data_t  w_data_o,
    input  logic   w_ready_i,
    // Responses
    input  logic   rd_resp_valid_i,
    input  logic   rd_resp_err_i,
    input  logic   wr_resp_valid_i,
    input  logic   wr_resp_err_i,
    // Status
    output logic   busy_o,
    output logic   done_o,
    output logic   error_o,
    output count_t bytes_remaining_o
);

    logic       cmd_err;
    logic       move;
    logic       idle;
    logic       drained;
    logic       axi_err;
    credit_t    rd_credit;
    credit_t    wr_space;
    depth_t     fifo_depth;
    logic       rd_req_fire;
    logic       wr_req_fire;
    logic       word_out;

    assign rd_req_fire = rd_req_valid_o && rd_req_ready_i;
    assign wr_req_fire = wr_req_valid_o && wr_req_ready_i;
    assign word_out    = w_valid_o && w_ready_i;

    // Write side may only ask for bytes already staged
    assign wr_space = {fifo_depth, 2'b00};

    dma_ctrl_fsm i_fsm (
        .clk, .rst_n, .go_i, .flush_i, .cmd_err_i(cmd_err), .drained_i(drained),
        .axi_err_i(axi_err), .state_o(), .move_o(move), .idle_o(idle),
        .busy_o, .done_o, .error_o
    );

    dma_cmd_check i_cmd_check (
        .src_addr_i, .dst_addr_i, .byte_count_i, .block_size_i, .cmd_err_o(cmd_err)
    );

    dma_xfer_tracker i_tracker (
        .clk, .rst_n, .idle_i(idle), .go_i, .byte_count_i, .rd_req_fire_i(rd_req_fire),
        .rd_req_len_i(rd_req_len_o), .wr_req_fire_i(wr_req_fire), .word_out_i(word_out),
        .rd_resp_valid_i, .rd_resp_err_i, .wr_resp_valid_i, .wr_resp_err_i, .flush_i,
        .rd_credit_o(rd_credit), .bytes_remaining_o, .drained_o(drained), .axi_err_o(axi_err)
    );

    dma_burst_splitter i_rd_split (
        .clk, .rst_n, .move_i(move), .idle_i(idle), .base_addr_i(src_addr_i), .byte_count_i,
        .block_size_i, .space_i(rd_credit), .req_ready_i(rd_req_ready_i),
        .req_valid_o(rd_req_valid_o), .req_addr_o(rd_req_addr_o), .req_len_o(rd_req_len_o)
    );

    dma_burst_splitter i_wr_split (
        .clk, .rst_n, .move_i(move), .idle_i(idle), .base_addr_i(dst_addr_i), .byte_count_i,
        .block_size_i, .space_i(wr_space), .req_ready_i(wr_req_ready_i),
        .req_valid_o(wr_req_valid_o), .req_addr_o(wr_req_addr_o), .req_len_o(wr_req_len_o)
    );

    // Flush in idle empties leftover data
    dma_data_fifo i_fifo (
        .clk, .rst_n, .clr_i(idle && flush_i), .wr_valid_i(r_valid_i), .wr_data_i(r_data_i),
        .rd_ready_i(w_ready_i), .wr_ready_o(r_ready_o), .rd_valid_o(w_valid_o),
        .rd_data_o(w_data_o), .depth_o(fifo_depth)
    );

endmodule

// ==== source/dma_data_fifo.sv ====
module dma_data_fifo import dma_geom_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   clr_i,
    input  logic   wr_valid_i,
    input  data_t  wr_data_i,
    input  logic   rd_ready_i,
    output logic   wr_ready_o,
    output logic   rd_valid_o,
    output data_t  rd_data_o,
    output depth_t depth_o
);

    data_t                 mem [FIFO_WORDS];
    logic [FIFO_PTR_W-1:0] wr_ptr;
    logic [FIFO_PTR_W-1:0] rd_ptr;
    depth_t                count;
    logic                  push;
    logic                  pop;

    assign wr_ready_o = (count != depth_t'(FIFO_WORDS));
    assign rd_valid_o = (count != '0);
    assign rd_data_o  = mem[rd_ptr];
    assign depth_o    = count;

    assign push = wr_valid_i && wr_ready_o;
    assign pop  = rd_valid_o && rd_ready_i;

    // Pointers wrap naturally, depth is a power of two
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (clr_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + depth_t'(push) - depth_t'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= wr_data_i;
        end
    end

endmodule

// ==== source/dma_burst_splitter.sv ====
module dma_burst_splitter import dma_geom_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    move_i,
    input  logic    idle_i,
    input  addr_t   base_addr_i,
    input  count_t  byte_count_i,
    input  count_t  block_size_i,
    input  credit_t space_i,
    input  logic    req_ready_i,
    output logic    req_valid_o,
    output addr_t   req_addr_o,
    output len_t    req_len_o
);

    count_t                 requested;
    count_t                 remaining;
    len_t                   block;
    logic [BLOCK_OFS_W-1:0] block_mask;
    logic [BLOCK_OFS_W-1:0] block_ofs;
    len_t                   align_len;
    logic                   more;
    logic                   req_fire;

    // Zero or oversized block falls back to the largest block
    always_comb begin
        if ((block_size_i == '0) || (block_size_i > count_t'(MAX_BLOCK_BYTES))) begin
            block = len_t'(MAX_BLOCK_BYTES);
        end else begin
            block = len_t'(block_size_i);
        end
    end

    assign block_mask = BLOCK_OFS_W'(block - len_t'(1));

    assign req_addr_o = base_addr_i + requested;

    // Stop at the next block boundary
    assign block_ofs = req_addr_o[BLOCK_OFS_W-1:0] & block_mask;
    assign align_len = block - len_t'(block_ofs);

    assign remaining = byte_count_i - requested;
    assign more      = (requested < byte_count_i);

    // Final request may be shorter than the distance to the boundary
    assign req_len_o = (remaining < count_t'(align_len)) ? len_t'(remaining) : align_len;

    assign req_valid_o = move_i && more && (space_i >= credit_t'(req_len_o));
    assign req_fire    = req_valid_o && req_ready_i;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            requested <= '0;
        end else if (idle_i) begin
            requested <= '0;
        end else if (req_fire) begin
            requested <= requested + count_t'(req_len_o);
        end
    end

endmodule

// ==== source/dma_xfer_tracker.sv ====
module dma_xfer_tracker
    import dma_geom_pkg::*;
    import dma_ctrl_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    idle_i,
    input  logic    go_i,
    input  count_t  byte_count_i,
    input  logic    rd_req_fire_i,
    input  len_t    rd_req_len_i,
    input  logic    wr_req_fire_i,
    input  logic    word_out_i,
    input  logic    rd_resp_valid_i,
    input  logic    rd_resp_err_i,
    input  logic    wr_resp_valid_i,
    input  logic    wr_resp_err_i,
    input  logic    flush_i,
    output credit_t rd_credit_o,
    output count_t  bytes_remaining_o,
    output logic    drained_o,
    output logic    axi_err_o
);

    count_t        bytes_remaining;
    credit_t       rd_credit;
    credit_t       credit_take;
    credit_t       credit_give;
    resp_pending_t wr_resp_pending;
    logic          resp_err;

    // Counted at the destination side, one word per FIFO pop
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bytes_remaining <= '0;
        end else if (idle_i && go_i) begin
            bytes_remaining <= byte_count_i;
        end else if (word_out_i) begin
            bytes_remaining <= bytes_remaining - count_t'(BYTES_PER_WORD);
        end
    end

    // Credits track free FIFO bytes not yet claimed by a read request
    assign credit_take = rd_req_fire_i ? credit_t'(rd_req_len_i) : '0;
    assign credit_give = word_out_i ? credit_t'(BYTES_PER_WORD) : '0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_credit <= credit_t'(FIFO_BYTES);
        end else if (idle_i) begin
            rd_credit <= credit_t'(FIFO_BYTES);
        end else begin
            rd_credit <= rd_credit - credit_take + credit_give;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_resp_pending <= '0;
        end else if (idle_i) begin
            wr_resp_pending <= '0;
        end else begin
            case ({wr_req_fire_i, wr_resp_valid_i})
                2'b10:   wr_resp_pending <= wr_resp_pending + resp_pending_t'(1);
                2'b01:   wr_resp_pending <= wr_resp_pending - resp_pending_t'(1);
                default: wr_resp_pending <= wr_resp_pending;
            endcase
        end
    end

    assign resp_err = (rd_resp_valid_i && rd_resp_err_i) || (wr_resp_valid_i && wr_resp_err_i);

    // Sticky until the engine is idle again or flushed
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            axi_err_o <= 1'b0;
        end else if (idle_i || flush_i) begin
            axi_err_o <= 1'b0;
        end else if (resp_err) begin
            axi_err_o <= 1'b1;
        end
    end

    assign rd_credit_o       = rd_credit;
    assign bytes_remaining_o = bytes_remaining;
    assign drained_o         = (bytes_remaining == '0) && (wr_resp_pending == '0);

endmodule

// ==== source/dma_cmd_check.sv ====
module dma_cmd_check import dma_geom_pkg::*; (
    input  addr_t  src_addr_i,
    input  addr_t  dst_addr_i,
    input  count_t byte_count_i,
    input  count_t block_size_i,
    output logic   cmd_err_o
);

    logic inv_src_addr;
    logic inv_dst_addr;
    logic inv_byte_count;
    logic inv_block_pow2;
    logic inv_block_align;

    // Both ends of the copy must start on a word
    assign inv_src_addr = |src_addr_i[WORD_OFS_W-1:0];
    assign inv_dst_addr = |dst_addr_i[WORD_OFS_W-1:0];

    // Zero count is legal, it just finishes at once
    assign inv_byte_count = |byte_count_i[WORD_OFS_W-1:0];

    // Zero block size passes both checks and selects the largest block
    assign inv_block_pow2  = |(block_size_i & (block_size_i - count_t'(1)));
    assign inv_block_align = |block_size_i[WORD_OFS_W-1:0];

    assign cmd_err_o = inv_src_addr    ||
                       inv_dst_addr    ||
                       inv_byte_count  ||
                       inv_block_pow2  ||
                       inv_block_align;

endmodule

// ==== source/dma_ctrl_fsm.sv ====
module dma_ctrl_fsm import dma_ctrl_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       go_i,
    input  logic       flush_i,
    input  logic       cmd_err_i,
    input  logic       drained_i,
    input  logic       axi_err_i,
    output dma_state_e state_o,
    output logic       move_o,
    output logic       idle_o,
    output logic       busy_o,
    output logic       done_o,
    output logic       error_o
);

    dma_state_e state_q;
    dma_state_e state_d;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= DMA_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            DMA_IDLE: begin
                // Command legality decides where go leads
                if (go_i) begin
                    state_d = cmd_err_i ? DMA_ERROR : DMA_MOVE;
                end
            end
            DMA_MOVE: begin
                if (drained_i) begin
                    state_d = axi_err_i ? DMA_ERROR : DMA_DONE;
                end
            end
            DMA_DONE: begin
                state_d = DMA_IDLE;
            end
            DMA_ERROR: begin
                // Held until software flushes
                if (flush_i) begin
                    state_d = DMA_IDLE;
                end
            end
            default: begin
                state_d = DMA_IDLE;
            end
        endcase
    end

    assign state_o = state_q;
    assign move_o  = (state_q == DMA_MOVE);
    assign idle_o  = (state_q == DMA_IDLE);
    assign busy_o  = (state_q != DMA_IDLE);
    assign done_o  = (state_q == DMA_DONE);
    assign error_o = (state_q == DMA_ERROR);

endmodule

// ==== common/dma_ctrl_pkg.sv ====
package dma_ctrl_pkg;

    // Control FSM states
    typedef enum logic [1:0] {
        DMA_IDLE  = 2'd0,
        DMA_MOVE  = 2'd1,
        DMA_DONE  = 2'd2,
        DMA_ERROR = 2'd3
    } dma_state_e;

    // Outstanding write responses, one per accepted write request
    typedef logic [3:0] resp_pending_t;

endpackage

// ==== common/dma_geom_pkg.sv ====
package dma_geom_pkg;

    // Data path geometry
    localparam int DATA_W         = 32;
    localparam int BYTES_PER_WORD = DATA_W / 8;
    localparam int WORD_OFS_W     = $clog2(BYTES_PER_WORD);
    localparam int ADDR_W         = 32;

    // Staging FIFO between read and write side
    localparam int FIFO_WORDS = 32;
    localparam int FIFO_BYTES = FIFO_WORDS * BYTES_PER_WORD;
    localparam int FIFO_PTR_W = $clog2(FIFO_WORDS);

    // Largest request is half the FIFO so reads and writes can overlap
    localparam int MAX_BLOCK_BYTES = FIFO_BYTES / 2;
    localparam int BLOCK_OFS_W     = $clog2(MAX_BLOCK_BYTES);

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [31:0]       count_t;

    // Widths hold the full value, hence the +1
    typedef logic [$clog2(MAX_BLOCK_BYTES+1)-1:0] len_t;
    typedef logic [$clog2(FIFO_BYTES+1)-1:0]      credit_t;
    typedef logic [$clog2(FIFO_WORDS+1)-1:0]      depth_t;

endpackage
